/* mmu.sv */
`timescale 1ns/10ps

module mmu import mmu_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  asid_t      asid,
	input  logic       is_user_mode,
	input  word_t      inst_vaddr,
	input  word_t      data_vaddr,

	input  tlb_index_t tlbrw_index,
	input  logic       tlbrw_we,
	input  tlb_entry_t tlbrw_wdata,
	output tlb_entry_t tlbrw_rdata,
	input  vpn2_t      tlbp_vpn2,
	output logic       tlbp_hit,
	output tlb_index_t tlbp_index,

	output word_t      inst_paddr,
	output logic       inst_miss,
	output logic       inst_invalid,
	output logic       inst_illegal,
	output word_t      data_paddr,
	output logic       data_miss,
	output logic       data_invalid,
	output logic       data_illegal,
	output logic       data_dirty
);

	logic inst_mapped;
	logic data_mapped;
	logic inst_hit;
	logic data_hit;
	pfn_t inst_pfn;
	pfn_t data_pfn;
	logic inst_valid;
	logic data_valid;
	logic data_dirty_bit;

	// Only kseg0 (100) and kseg1 (101) bypass the TLB.
	function automatic logic is_mapped(input word_t vaddr);
		return !vaddr[31] || (vaddr[31:30] == 2'b11);
	endfunction

	assign inst_mapped = is_mapped(inst_vaddr);
	assign data_mapped = is_mapped(data_vaddr);

	assign inst_illegal = is_user_mode && inst_vaddr[31];
	assign inst_miss    = inst_mapped && !inst_hit;
	assign inst_invalid = inst_mapped && !inst_valid;
	assign inst_paddr   = inst_mapped ? {inst_pfn, inst_vaddr[page_offset_bits-1:0]}
		: {3'b000, inst_vaddr[28:0]};

	assign data_illegal = is_user_mode && data_vaddr[31];
	assign data_miss    = data_mapped && !data_hit;
	assign data_invalid = data_mapped && !data_valid;
	assign data_dirty   = !data_mapped || data_dirty_bit; // High means the page is writable.
	assign data_paddr   = data_mapped ? {data_pfn, data_vaddr[page_offset_bits-1:0]}
		: {3'b000, data_vaddr[28:0]};

	tlb tlb_inst (
		.clk,
		.reset,
		.asid,
		.inst_vaddr,
		.data_vaddr,
		.inst_hit,
		.inst_pfn,
		.inst_valid,
		.data_hit,
		.data_pfn,
		.data_valid,
		.data_dirty_bit,
		.tlbrw_index,
		.tlbrw_we,
		.tlbrw_wdata,
		.tlbrw_rdata,
		.tlbp_vpn2,
		.tlbp_hit,
		.tlbp_index
	);

	a_kernel_legal: assert property (@(posedge clk) disable iff (reset)
		!is_user_mode |-> !(inst_illegal || data_illegal))
		else $error("Illegal address flagged in kernel mode.");

endmodule

/* mmu_pkg.sv */
package mmu_pkg;

	typedef logic [31:0] word_t;

	localparam int tlb_entries = 16;
	localparam int page_offset_bits = 12;

	typedef logic [$clog2(tlb_entries)-1:0] tlb_index_t;
	typedef logic [18:0] vpn2_t;
	typedef logic [7:0]  asid_t;
	typedef logic [19:0] pfn_t;

	// One entry maps an even and an odd 4 KB page.
	typedef struct packed {
		vpn2_t vpn2;
		asid_t asid;
		logic  is_global; // The G bit of the entry.
		pfn_t  pfn0;
		logic  valid0;
		logic  dirty0;
		pfn_t  pfn1;
		logic  valid1;
		logic  dirty1;
	} tlb_entry_t;

	typedef enum logic [1:0] {
		cmd_none  = 2'd0,
		cmd_tlbr  = 2'd1,
		cmd_tlbwi = 2'd2,
		cmd_tlbp  = 2'd3
	} tlb_cmd_e;

	typedef enum logic [1:0] {
		resp_okay   = 2'b00,
		resp_slverr = 2'b10
	} axi_resp_e;

	typedef enum logic {
		rd_idle = 1'b0,
		rd_data = 1'b1
	} axi_rd_state_e;

	localparam word_t reg_entry_hi  = 32'h0000_0000;
	localparam word_t reg_entry_lo0 = 32'h0000_0004;
	localparam word_t reg_entry_lo1 = 32'h0000_0008;
	localparam word_t reg_index     = 32'h0000_000c;
	localparam word_t reg_status    = 32'h0000_0010;
	localparam word_t reg_command   = 32'h0000_0014;

	// Field positions inside the register words.
	localparam int hi_vpn2_lsb          = 13;
	localparam int lo_pfn_msb           = 25;
	localparam int lo_pfn_lsb           = 6;
	localparam int lo_dirty_bit         = 2;
	localparam int lo_valid_bit         = 1;
	localparam int lo_global_bit        = 0;
	localparam int index_probe_fail_bit = 31;
	localparam int status_user_bit      = 0;

	// Bits that a register keeps; all others read as zero.
	localparam word_t hi_mask     = 32'hffff_e0ff;
	localparam word_t lo_mask     = 32'h03ff_ffc7;
	localparam word_t index_mask  = 32'h8000_000f;
	localparam word_t status_mask = 32'h0000_0001;

endpackage

/* mmu_regs.sv */
`timescale 1ns/10ps

module mmu_regs import mmu_pkg::*; (
	input  logic       clk,
	input  logic       reset,

	input  word_t      awaddr,
	input  logic       awvalid,
	output logic       awready,
	input  word_t      wdata,
	input  logic       wvalid,
	output logic       wready,
	output logic       bvalid,
	input  logic       bready,
	output axi_resp_e  bresp,
	input  word_t      araddr,
	input  logic       arvalid,
	output logic       arready,
	output logic       rvalid,
	input  logic       rready,
	output word_t      rdata,
	output axi_resp_e  rresp,

	output asid_t      asid,
	output logic       is_user_mode,
	output tlb_index_t tlbrw_index,
	output logic       tlbrw_we,
	output tlb_entry_t tlbrw_wdata,
	input  tlb_entry_t tlbrw_rdata,
	output vpn2_t      tlbp_vpn2,
	input  logic       tlbp_hit,
	input  tlb_index_t tlbp_index
);

	word_t         entry_hi_r;
	word_t         entry_lo0_r;
	word_t         entry_lo1_r;
	word_t         index_r;
	word_t         status_r;
	tlb_cmd_e      cmd_q;
	axi_rd_state_e rd_state;
	logic          wr_accept;
	word_t         rd_word;

	function automatic logic reg_known(input word_t addr);
		return addr inside {reg_entry_hi, reg_entry_lo0, reg_entry_lo1,
			reg_index, reg_status, reg_command};
	endfunction

	function automatic word_t make_lo(input pfn_t pfn, input logic d, input logic v,
		input logic g);
		word_t w;
		w = '0;
		w[lo_pfn_msb:lo_pfn_lsb] = pfn;
		w[lo_dirty_bit] = d;
		w[lo_valid_bit] = v;
		w[lo_global_bit] = g;
		return w;
	endfunction

	assign wr_accept = awvalid && wvalid && !bvalid;
	assign awready   = wr_accept;
	assign wready    = wr_accept;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			entry_hi_r  <= '0;
			entry_lo0_r <= '0;
			entry_lo1_r <= '0;
			index_r     <= '0;
			status_r    <= '0;
			cmd_q       <= cmd_none;
			bvalid      <= 1'b0;
		end
		else
		begin
			cmd_q <= cmd_none;
			if (wr_accept)
			begin
				case (awaddr)
				reg_entry_hi:  entry_hi_r  <= wdata & hi_mask;
				reg_entry_lo0: entry_lo0_r <= wdata & lo_mask;
				reg_entry_lo1: entry_lo1_r <= wdata & lo_mask;
				reg_index:     index_r     <= wdata & index_mask;
				reg_status:    status_r    <= wdata & status_mask;
				reg_command:   cmd_q       <= tlb_cmd_e'(wdata[1:0]);
				default:       ;
				endcase
			end
			// The command runs one cycle after its write, while no new write is accepted.
			case (cmd_q)
			cmd_tlbr:
			begin
				entry_hi_r <= '0;
				entry_hi_r[31:hi_vpn2_lsb] <= tlbrw_rdata.vpn2;
				entry_hi_r[7:0] <= tlbrw_rdata.asid;
				entry_lo0_r <= make_lo(tlbrw_rdata.pfn0, tlbrw_rdata.dirty0,
					tlbrw_rdata.valid0, tlbrw_rdata.is_global);
				entry_lo1_r <= make_lo(tlbrw_rdata.pfn1, tlbrw_rdata.dirty1,
					tlbrw_rdata.valid1, tlbrw_rdata.is_global);
			end
			cmd_tlbp:
			begin
				index_r <= word_t'(tlbp_index);
				index_r[index_probe_fail_bit] <= !tlbp_hit;
			end
			default: ;
			endcase
			if (wr_accept)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_accept)
			bresp <= reg_known(awaddr) ? resp_okay : resp_slverr;
	end

	always_comb
	begin
		case (araddr)
		reg_entry_hi:  rd_word = entry_hi_r;
		reg_entry_lo0: rd_word = entry_lo0_r;
		reg_entry_lo1: rd_word = entry_lo1_r;
		reg_index:     rd_word = index_r;
		reg_status:    rd_word = status_r;
		default:       rd_word = '0; // The command register is write-only.
		endcase
	end

	assign arready = (rd_state == rd_idle);
	assign rvalid  = (rd_state == rd_data);

	always_ff @(posedge clk)
	begin
		if (reset)
			rd_state <= rd_idle;
		else if (rd_state == rd_idle && arvalid)
			rd_state <= rd_data;
		else if (rd_state == rd_data && rready)
			rd_state <= rd_idle;
	end

	always_ff @(posedge clk)
	begin
		if (arvalid && arready)
		begin
			rdata <= rd_word;
			rresp <= reg_known(araddr) ? resp_okay : resp_slverr;
		end
	end

	assign asid         = entry_hi_r[7:0];
	assign is_user_mode = status_r[status_user_bit];
	assign tlbrw_index  = index_r[$bits(tlb_index_t)-1:0];
	assign tlbrw_we     = (cmd_q == cmd_tlbwi);
	assign tlbp_vpn2    = entry_hi_r[31:hi_vpn2_lsb];

	always_comb
	begin
		tlbrw_wdata.vpn2      = entry_hi_r[31:hi_vpn2_lsb];
		tlbrw_wdata.asid      = entry_hi_r[7:0];
		tlbrw_wdata.is_global = entry_lo0_r[lo_global_bit] && entry_lo1_r[lo_global_bit];
		tlbrw_wdata.pfn0      = entry_lo0_r[lo_pfn_msb:lo_pfn_lsb];
		tlbrw_wdata.valid0    = entry_lo0_r[lo_valid_bit];
		tlbrw_wdata.dirty0    = entry_lo0_r[lo_dirty_bit];
		tlbrw_wdata.pfn1      = entry_lo1_r[lo_pfn_msb:lo_pfn_lsb];
		tlbrw_wdata.valid1    = entry_lo1_r[lo_valid_bit];
		tlbrw_wdata.dirty1    = entry_lo1_r[lo_dirty_bit];
	end

	a_bvalid_hold: assert property (@(posedge clk) disable iff (reset)
		bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready.");

	a_rvalid_hold: assert property (@(posedge clk) disable iff (reset)
		rvalid && !rready |=> rvalid)
		else $error("rvalid dropped before rready.");

	a_we_pulse: assert property (@(posedge clk) disable iff (reset)
		tlbrw_we |=> !tlbrw_we)
		else $error("TLB write strobe lasted more than one cycle.");

endmodule

/* mmu_subsys.f */
mmu_pkg.sv
tlb.sv
mmu.sv
mmu_regs.sv
mmu_top.sv
tb_clock.sv
tb_mmu_top.sv

/* mmu_top.sv */
`timescale 1ns/10ps

module mmu_top import mmu_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  word_t     inst_vaddr,
	input  word_t     data_vaddr,

	input  word_t     awaddr,
	input  logic      awvalid,
	output logic      awready,
	input  word_t     wdata,
	input  logic      wvalid,
	output logic      wready,
	output logic      bvalid,
	input  logic      bready,
	output axi_resp_e bresp,
	input  word_t     araddr,
	input  logic      arvalid,
	output logic      arready,
	output logic      rvalid,
	input  logic      rready,
	output word_t     rdata,
	output axi_resp_e rresp,

	output word_t     inst_paddr,
	output logic      inst_miss,
	output logic      inst_invalid,
	output logic      inst_illegal,
	output word_t     data_paddr,
	output logic      data_miss,
	output logic      data_invalid,
	output logic      data_illegal,
	output logic      data_dirty
);

	asid_t      asid;
	logic       is_user_mode;
	tlb_index_t tlbrw_index;
	logic       tlbrw_we;
	tlb_entry_t tlbrw_wdata;
	tlb_entry_t tlbrw_rdata;
	vpn2_t      tlbp_vpn2;
	logic       tlbp_hit;
	tlb_index_t tlbp_index;

	mmu_regs regs_inst (
		.clk, .reset,
		.awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
		.bvalid, .bready, .bresp,
		.araddr, .arvalid, .arready, .rvalid, .rready, .rdata, .rresp,
		.asid, .is_user_mode,
		.tlbrw_index, .tlbrw_we, .tlbrw_wdata, .tlbrw_rdata,
		.tlbp_vpn2, .tlbp_hit, .tlbp_index
	);

	mmu mmu_inst (
		.clk, .reset, .asid, .is_user_mode, .inst_vaddr, .data_vaddr,
		.tlbrw_index, .tlbrw_we, .tlbrw_wdata, .tlbrw_rdata,
		.tlbp_vpn2, .tlbp_hit, .tlbp_index,
		.inst_paddr, .inst_miss, .inst_invalid, .inst_illegal,
		.data_paddr, .data_miss, .data_invalid, .data_illegal, .data_dirty
	);

endmodule

/* run_sim.sh */
#!/bin/sh
# Builds the MMU testbench with Verilator, runs it and judges the log.

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module tb_mmu_top \
	-f mmu_subsys.f --Mdir obj_dir -o sim_mmu
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status."
	exit 1
fi

./obj_dir/sim_mmu > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status."
	exit 1
fi

if grep -q "=== FAIL ===" "$log"; then
	echo "Simulation reported a failure."
	exit 1
fi

echo "Simulation finished without failures."
exit 0

/* tb_clock.sv */
`timescale 1ns/10ps

module tb_clock (
	output logic clk,
	output logic reset
);

	localparam int half_period_ns = 10; // 20 ns clock period.
	localparam int reset_cycles   = 2;

	initial
	begin
		clk = 1'b0;
		forever #(half_period_ns) clk = ~clk;
	end

	initial
	begin
		reset <= 1'b1;
		repeat (reset_cycles) @(posedge clk);
		reset <= 1'b0; // Released on a rising edge.
	end

endmodule

/* tb_mmu_top.sv */
`timescale 1ns/10ps

module tb_mmu_top import mmu_pkg::*; ();

	localparam int num_unmapped = 20; // Lookups per mode.
	localparam int num_random   = 400;
	localparam int num_tlbr     = 8;
	localparam int num_tlbp     = 8;
	localparam int num_bp       = 12;
	localparam int num_ops      = 40 + tlb_entries * 5 + num_unmapped * 2 + num_random * 3
		+ num_tlbr * 5 + num_tlbp * 8 + num_bp * 3;
	localparam longint timeout_ns = longint'(num_ops) * 20 * 20 + 10000;
	localparam int unsigned rand_seed = 32'hab8a_8adc;

	typedef struct packed {
		word_t paddr;
		logic  miss;
		logic  invalid;
		logic  illegal;
		logic  dirty;
	} expect_t;

	logic      clk;
	logic      reset;
	word_t     inst_vaddr;
	word_t     data_vaddr;
	word_t     awaddr;
	logic      awvalid;
	logic      awready;
	word_t     wdata;
	logic      wvalid;
	logic      wready;
	logic      bvalid;
	logic      bready;
	axi_resp_e bresp;
	word_t     araddr;
	logic      arvalid;
	logic      arready;
	logic      rvalid;
	logic      rready;
	word_t     rdata;
	axi_resp_e rresp;
	word_t     inst_paddr;
	logic      inst_miss;
	logic      inst_invalid;
	logic      inst_illegal;
	word_t     data_paddr;
	logic      data_miss;
	logic      data_invalid;
	logic      data_illegal;
	logic      data_dirty;

	tlb_entry_t shadow [tlb_entries]; // Mirror of every entry written over the bus.
	asid_t      model_asid;
	logic       model_user;
	logic       check_req;
	expect_t    exp_inst;
	expect_t    exp_data;

	tb_clock clock_gen (.clk, .reset);

	mmu_top dut (.*);

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp)
		begin
			$display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
			$display("=== FAIL ===");
			$fatal(1, "Value mismatch on %s.", name);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("ERROR at %0t: %s is %b, expected %b", $time, name, got, exp);
			$display("=== FAIL ===");
			$fatal(1, "Flag mismatch on %s.", name);
		end
	endtask

	task automatic check_resp(input string name, input axi_resp_e got, input axi_resp_e exp);
		if (got !== exp)
		begin
			$display("ERROR at %0t: %s is %s, expected %s", $time, name, got.name(), exp.name());
			$display("=== FAIL ===");
			$fatal(1, "Response mismatch on %s.", name);
		end
	endtask

	function automatic word_t hi_word(input vpn2_t vpn2, input asid_t id);
		return {vpn2, 5'b0, id};
	endfunction

	function automatic word_t lo_word(input pfn_t pfn, input logic d, input logic v,
		input logic g);
		return {6'b0, pfn, 3'b0, d, v, g};
	endfunction

	function automatic word_t random_lo();
		word_t r;
		r = $urandom;
		return lo_word(pfn_t'($urandom), r[0], r[1], r[2]);
	endfunction

	// Lowest index whose VPN2 matches and that is global or owned by the ASID, else -1.
	function automatic int lowest_match(input vpn2_t vpn2, input asid_t id);
		for (int i = 0; i < tlb_entries; i++)
			if (shadow[i].vpn2 == vpn2 && (shadow[i].is_global || shadow[i].asid == id))
				return i;
		return -1;
	endfunction

	function automatic expect_t ref_translate(input word_t vaddr, input asid_t id,
		input logic user);
		expect_t    r;
		tlb_entry_t e;
		int         k;
		logic       odd;
		r = '0;
		r.illegal = user && vaddr[31];
		if (vaddr[31:30] == 2'b10)
		begin
			r.paddr = {3'b000, vaddr[28:0]}; // kseg0 and kseg1 bypass the TLB.
			r.dirty = 1'b1;
			return r;
		end
		k = lowest_match(vaddr[31:13], id);
		odd = vaddr[12];
		r.paddr = {20'h0, vaddr[11:0]};
		r.miss = (k < 0);
		r.invalid = 1'b1;
		if (k >= 0)
		begin
			e = shadow[k];
			r.paddr[31:12] = odd ? e.pfn1 : e.pfn0;
			r.invalid = !(odd ? e.valid1 : e.valid0);
			r.dirty = odd ? e.dirty1 : e.dirty0;
		end
		return r;
	endfunction

	function automatic word_t pick_address();
		word_t a;
		int    k;
		a = $urandom;
		k = int'($urandom % tlb_entries);
		if ($urandom % 5 < 3)
			a[31:13] = shadow[k].vpn2; // Aim most lookups at stored page pairs.
		return a;
	endfunction

	function automatic word_t unmapped_address();
		word_t a;
		a = $urandom;
		a[31:30] = 2'b10;
		return a;
	endfunction

	task automatic axi_write(input word_t addr, input word_t data, input int hold,
		output axi_resp_e resp);
		awaddr  <= addr;
		wdata   <= data;
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		do
			@(posedge clk);
		while (!(awready && wready));
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		do
			@(posedge clk);
		while (!bvalid);
		resp = bresp;
		for (int i = 0; i < hold; i++)
		begin
			@(posedge clk);
			check_flag("bvalid", bvalid, 1'b1);
		end
		bready <= 1'b1;
		@(posedge clk);
		bready <= 1'b0;
	endtask

	task automatic axi_read(input word_t addr, input int hold, output word_t data,
		output axi_resp_e resp);
		araddr  <= addr;
		arvalid <= 1'b1;
		do
			@(posedge clk);
		while (!arready);
		arvalid <= 1'b0;
		do
			@(posedge clk);
		while (!rvalid);
		data = rdata;
		resp = rresp;
		for (int i = 0; i < hold; i++)
		begin
			@(posedge clk);
			check_flag("rvalid", rvalid, 1'b1);
			check_word("rdata", rdata, data);
		end
		rready <= 1'b1;
		@(posedge clk);
		rready <= 1'b0;
	endtask

	task automatic set_reg(input word_t addr, input word_t data);
		axi_resp_e resp;
		axi_write(addr, data, 0, resp);
		check_resp("bresp", resp, resp_okay);
	endtask

	task automatic expect_reg(input word_t addr, input word_t exp);
		word_t     data;
		axi_resp_e resp;
		axi_read(addr, 0, data, resp);
		check_resp("rresp", resp, resp_okay);
		check_word("rdata", data, exp);
	endtask

	task automatic load_entry(input int idx);
		tlb_entry_t e;
		word_t      r;
		int         k;
		r = $urandom;
		e.vpn2 = vpn2_t'($urandom);
		if (idx > 0 && r[9:8] == 2'b00)
		begin
			k = int'($urandom % idx);
			e.vpn2 = shadow[k].vpn2; // Shared VPN2s exercise the priority rule.
		end
		e.asid = asid_t'($urandom % 4);
		e.is_global = r[4] & r[5];
		e.pfn0 = pfn_t'($urandom);
		e.valid0 = r[0] | r[6];
		e.dirty0 = r[1];
		e.pfn1 = pfn_t'($urandom);
		e.valid1 = r[2] | r[7];
		e.dirty1 = r[3];
		set_reg(reg_entry_hi, hi_word(e.vpn2, e.asid));
		set_reg(reg_entry_lo0, lo_word(e.pfn0, e.dirty0, e.valid0, r[4]));
		set_reg(reg_entry_lo1, lo_word(e.pfn1, e.dirty1, e.valid1, r[5]));
		set_reg(reg_index, word_t'(idx));
		set_reg(reg_command, word_t'(cmd_tlbwi));
		shadow[idx] = e;
	endtask

	task automatic apply_lookup(input word_t iaddr, input word_t daddr);
		inst_vaddr <= iaddr;
		data_vaddr <= daddr;
		check_req  <= 1'b1;
		@(posedge clk);
		check_req  <= 1'b0;
	endtask

	always @(posedge clk)
	begin
		if (check_req)
		begin
			exp_inst = ref_translate(inst_vaddr, model_asid, model_user);
			exp_data = ref_translate(data_vaddr, model_asid, model_user);
			check_word("inst_paddr", inst_paddr, exp_inst.paddr);
			check_flag("inst_miss", inst_miss, exp_inst.miss);
			check_flag("inst_invalid", inst_invalid, exp_inst.invalid);
			check_flag("inst_illegal", inst_illegal, exp_inst.illegal);
			check_word("data_paddr", data_paddr, exp_data.paddr);
			check_flag("data_miss", data_miss, exp_data.miss);
			check_flag("data_invalid", data_invalid, exp_data.invalid);
			check_flag("data_illegal", data_illegal, exp_data.illegal);
			check_flag("data_dirty", data_dirty, exp_data.dirty);
		end
	end

	initial
	begin
		#(timeout_ns);
		$display("Watchdog expired after %0d ns, the DUT or a bus handshake hangs.", timeout_ns);
		$display("=== FAIL ===");
		$fatal(1, "Timeout.");
	end

	initial
	begin
		word_t     data;
		word_t     hi_val;
		word_t     lo0_val;
		word_t     lo1_val;
		word_t     idx_val;
		axi_resp_e resp;
		int        k;
		vpn2_t     vpn2;
		asid_t     id;

		void'($urandom(rand_seed));
		inst_vaddr <= '0;
		data_vaddr <= '0;
		awaddr     <= '0;
		awvalid    <= 1'b0;
		wdata      <= '0;
		wvalid     <= 1'b0;
		bready     <= 1'b0;
		araddr     <= '0;
		arvalid    <= 1'b0;
		rready     <= 1'b0;
		check_req  <= 1'b0;
		for (int i = 0; i < tlb_entries; i++)
			shadow[i] = '0;
		model_asid = '0;
		model_user = 1'b0;
		do
			@(posedge clk);
		while (reset);

		expect_reg(reg_entry_hi, '0);
		expect_reg(reg_entry_lo0, '0);
		expect_reg(reg_entry_lo1, '0);
		expect_reg(reg_index, '0);
		expect_reg(reg_status, '0);
		expect_reg(reg_command, '0);
		hi_val = hi_word(vpn2_t'($urandom), asid_t'($urandom));
		lo0_val = random_lo();
		lo1_val = random_lo();
		idx_val = $urandom & 32'h8000_000f;
		set_reg(reg_entry_hi, hi_val);
		set_reg(reg_entry_lo0, lo0_val);
		set_reg(reg_entry_lo1, lo1_val);
		set_reg(reg_index, idx_val);
		set_reg(reg_status, 32'h1);
		expect_reg(reg_entry_hi, hi_val);
		expect_reg(reg_entry_lo0, lo0_val);
		expect_reg(reg_entry_lo1, lo1_val);
		expect_reg(reg_index, idx_val);
		expect_reg(reg_status, 32'h1);
		axi_write(32'h0000_0020, 32'hffff_ffff, 0, resp);
		check_resp("bresp", resp, resp_slverr);
		axi_read(32'h0000_0018, 0, data, resp);
		check_resp("rresp", resp, resp_slverr);
		check_word("rdata", data, '0);
		expect_reg(reg_entry_hi, hi_val);
		model_asid = hi_val[7:0];

		for (int m = 0; m < 2; m++)
		begin
			set_reg(reg_status, word_t'(m));
			model_user = (m == 1);
			for (int i = 0; i < num_unmapped; i++)
				apply_lookup(unmapped_address(), unmapped_address());
		end

		for (int i = 0; i < tlb_entries; i++)
			load_entry(i);

		for (int i = 0; i < num_random; i++)
		begin
			k = int'($urandom % tlb_entries);
			id = ($urandom % 2 == 0) ? shadow[k].asid : asid_t'($urandom % 5);
			data = word_t'($urandom % 2);
			set_reg(reg_entry_hi, hi_word(vpn2_t'($urandom), id));
			set_reg(reg_status, data);
			model_asid = id;
			model_user = data[0];
			apply_lookup(pick_address(), pick_address());
		end

		for (int i = 0; i < num_tlbr; i++)
		begin
			k = int'($urandom % tlb_entries);
			set_reg(reg_index, word_t'(k));
			set_reg(reg_command, word_t'(cmd_tlbr));
			expect_reg(reg_entry_hi, hi_word(shadow[k].vpn2, shadow[k].asid));
			expect_reg(reg_entry_lo0, lo_word(shadow[k].pfn0, shadow[k].dirty0,
				shadow[k].valid0, shadow[k].is_global));
			expect_reg(reg_entry_lo1, lo_word(shadow[k].pfn1, shadow[k].dirty1,
				shadow[k].valid1, shadow[k].is_global));
		end

		for (int i = 0; i < num_tlbp; i++)
		begin
			k = int'($urandom % tlb_entries);
			id = shadow[k].is_global ? asid_t'($urandom) : shadow[k].asid;
			set_reg(reg_entry_hi, hi_word(shadow[k].vpn2, id));
			set_reg(reg_command, word_t'(cmd_tlbp));
			expect_reg(reg_index, word_t'(lowest_match(shadow[k].vpn2, id)));
			do
			begin
				vpn2 = vpn2_t'($urandom);
				id = asid_t'($urandom);
			end
			while (lowest_match(vpn2, id) >= 0);
			set_reg(reg_entry_hi, hi_word(vpn2, id));
			set_reg(reg_command, word_t'(cmd_tlbp));
			axi_read(reg_index, 0, data, resp);
			check_resp("rresp", resp, resp_okay);
			check_flag("index probe-failed bit", data[31], 1'b1);
		end

		for (int i = 0; i < num_bp; i++)
		begin
			lo1_val = random_lo();
			axi_write(reg_entry_lo1, lo1_val, int'($urandom % 8), resp);
			check_resp("bresp", resp, resp_okay);
			axi_read(reg_entry_lo1, int'($urandom % 8), data, resp);
			check_resp("rresp", resp, resp_okay);
			check_word("rdata", data, lo1_val);
			axi_read(32'h0000_0040, int'($urandom % 8), data, resp);
			check_resp("rresp", resp, resp_slverr);
			check_word("rdata", data, '0);
		end

		$display("=== PASS ===");
		$finish;
	end

endmodule

/* tlb.sv */
`timescale 1ns/10ps

module tlb import mmu_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  asid_t      asid,
	input  word_t      inst_vaddr,
	input  word_t      data_vaddr,

	output logic       inst_hit,
	output pfn_t       inst_pfn,
	output logic       inst_valid,
	output logic       data_hit,
	output pfn_t       data_pfn,
	output logic       data_valid,
	output logic       data_dirty_bit,

	input  tlb_index_t tlbrw_index,
	input  logic       tlbrw_we,
	input  tlb_entry_t tlbrw_wdata,
	output tlb_entry_t tlbrw_rdata,

	input  vpn2_t      tlbp_vpn2,
	output logic       tlbp_hit,
	output tlb_index_t tlbp_index
);

	tlb_entry_t entries [tlb_entries];

	tlb_index_t inst_index;
	tlb_index_t data_index;
	tlb_entry_t inst_entry;
	tlb_entry_t data_entry;
	logic       inst_odd;
	logic       data_odd;

	function automatic logic entry_match(
		input tlb_entry_t e,
		input vpn2_t      vpn2,
		input asid_t      id
	);
		return (e.vpn2 == vpn2) && (e.is_global || e.asid == id);
	endfunction

	// Scans downwards so that the lowest matching index is the one kept.
	function automatic logic [$bits(tlb_index_t):0] search(
		input vpn2_t      vpn2,
		input asid_t      id,
		input tlb_entry_t ents [tlb_entries]
	);
		logic [$bits(tlb_index_t):0] result;
		result = '0;
		for (int i = tlb_entries - 1; i >= 0; i--)
		begin
			if (entry_match(ents[i], vpn2, id))
				result = {1'b1, tlb_index_t'(i)};
		end
		return result;
	endfunction

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < tlb_entries; i++)
				entries[i] <= '0;
		end
		else if (tlbrw_we)
			entries[tlbrw_index] <= tlbrw_wdata;
	end

	assign tlbrw_rdata = entries[tlbrw_index];

	assign {inst_hit, inst_index} = search(inst_vaddr[31:page_offset_bits+1], asid, entries);
	assign {data_hit, data_index} = search(data_vaddr[31:page_offset_bits+1], asid, entries);
	assign {tlbp_hit, tlbp_index} = search(tlbp_vpn2, asid, entries); // Probe uses the entry_hi ASID.

	assign inst_entry = entries[inst_index];
	assign data_entry = entries[data_index];
	assign inst_odd   = inst_vaddr[page_offset_bits];
	assign data_odd   = data_vaddr[page_offset_bits];

	// A miss reports frame zero with both flags low.
	assign inst_pfn   = !inst_hit ? '0 : (inst_odd ? inst_entry.pfn1 : inst_entry.pfn0);
	assign inst_valid = inst_hit && (inst_odd ? inst_entry.valid1 : inst_entry.valid0);

	assign data_pfn       = !data_hit ? '0 : (data_odd ? data_entry.pfn1 : data_entry.pfn0);
	assign data_valid     = data_hit && (data_odd ? data_entry.valid1 : data_entry.valid0);
	assign data_dirty_bit = data_hit && (data_odd ? data_entry.dirty1 : data_entry.dirty0);

	property p_write_readback;
		@(posedge clk) disable iff (reset)
		tlbrw_we |=> (entries[$past(tlbrw_index)] == $past(tlbrw_wdata));
	endproperty

	a_write_readback: assert property (p_write_readback)
		else $error("TLB entry does not hold the value written to it.");

endmodule
